// File: logic/exec_core.sv
module exec_core (
    input  logic              clk,
    input  logic              rst_n,
    input  exec_pkg::wb_req_t wb_req,
    output logic              wb_ack,
    output exec_pkg::stage_t  retire
);

    exec_pkg::ex_op_t          ex_op;
    exec_pkg::stage_t          ex_result;
    exec_pkg::stage_t          dm1;
    exec_pkg::stage_t          dm2;
    exec_pkg::stage_t          dm3;
    exec_pkg::stage_t          wb;
    logic [exec_pkg::xlen-1:0] rdata1;
    logic [exec_pkg::xlen-1:0] rdata2;
    logic [2:0]                sel_a;
    logic [2:0]                sel_b;

    //////////////////////////////
    // Issue and operand fetch
    //////////////////////////////
    instr_decoder u_decoder (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_ack (wb_ack),
        .ex_op  (ex_op)
    );

    register_file u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (ex_op.rs1),
        .rs2    (ex_op.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wr     (wb)
    );

    //////////////////////////////
    // Execute and result stages
    //////////////////////////////
    forwarding_unit u_fwd (
        .ex_op (ex_op),
        .dm1   (dm1),
        .dm2   (dm2),
        .dm3   (dm3),
        .wb    (wb),
        .sel_a (sel_a),
        .sel_b (sel_b)
    );

    execute_stage u_exec (
        .ex_op     (ex_op),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .dm1       (dm1),
        .dm2       (dm2),
        .dm3       (dm3),
        .wb        (wb),
        .ex_result (ex_result)
    );

    result_pipe u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_result (ex_result),
        .dm1       (dm1),
        .dm2       (dm2),
        .dm3       (dm3),
        .wb        (wb),
        .retire    (retire)
    );

endmodule

// File: logic/exec_pkg.sv
package exec_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // Major opcodes handled by the slice
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // Operand source selects
    localparam logic [2:0] src_regfile = 3'd0;
    localparam logic [2:0] src_const   = 3'd1;
    localparam logic [2:0] src_dm1     = 3'd2;
    localparam logic [2:0] src_dm2     = 3'd3;
    localparam logic [2:0] src_dm3     = 3'd4;
    localparam logic [2:0] src_wb      = 3'd5;

    //////////////////////////////
    // Instruction word
    //////////////////////////////
    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fields_t;

    // Same 32 bits seen as R-type or I-type
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    //////////////////////////////
    // Pipeline bundles
    //////////////////////////////
    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        alu_op_e               alu_op;
        logic                  const_a;
        logic                  const_b;
        logic [xlen-1:0]       const_val;
    } ex_op_t;

    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } stage_t;

    // Wishbone classic issue request, write only
    typedef struct packed {
        logic   cyc;
        logic   stb;
        instr_u dat;
    } wb_req_t;

endpackage

// File: logic/execute_stage.sv
module execute_stage (
    input  exec_pkg::ex_op_t          ex_op,
    input  logic [exec_pkg::xlen-1:0] rdata1,
    input  logic [exec_pkg::xlen-1:0] rdata2,
    input  logic [2:0]                sel_a,
    input  logic [2:0]                sel_b,
    input  exec_pkg::stage_t          dm1,
    input  exec_pkg::stage_t          dm2,
    input  exec_pkg::stage_t          dm3,
    input  exec_pkg::stage_t          wb,
    output exec_pkg::stage_t          ex_result
);

    logic [exec_pkg::xlen-1:0] op_a;
    logic [exec_pkg::xlen-1:0] op_b;
    logic [exec_pkg::xlen-1:0] alu_out;
    logic [4:0]                shamt;

    // Six-way operand select
    function automatic logic [exec_pkg::xlen-1:0] operand(
        input logic [2:0]                sel,
        input logic [exec_pkg::xlen-1:0] rdata,
        input logic [exec_pkg::xlen-1:0] konst,
        input exec_pkg::stage_t          s_dm1,
        input exec_pkg::stage_t          s_dm2,
        input exec_pkg::stage_t          s_dm3,
        input exec_pkg::stage_t          s_wb
    );
        logic [exec_pkg::xlen-1:0] val;
        case (sel)
            exec_pkg::src_const: val = konst;
            exec_pkg::src_dm1:   val = s_dm1.data;
            exec_pkg::src_dm2:   val = s_dm2.data;
            exec_pkg::src_dm3:   val = s_dm3.data;
            exec_pkg::src_wb:    val = s_wb.data;
            default:             val = rdata;
        endcase
        return val;
    endfunction

    // No PC in this slice, so the A-side constant is zero
    assign op_a  = operand(sel_a, rdata1, '0, dm1, dm2, dm3, wb);
    assign op_b  = operand(sel_b, rdata2, ex_op.const_val, dm1, dm2, dm3, wb);
    assign shamt = op_b[4:0];

    //////////////////////////////
    // ALU
    //////////////////////////////
    always_comb
    begin
        case (ex_op.alu_op)
            exec_pkg::alu_add:    alu_out = op_a + op_b;
            exec_pkg::alu_sub:    alu_out = op_a - op_b;
            exec_pkg::alu_sll:    alu_out = op_a << shamt;
            exec_pkg::alu_slt:
                alu_out = {{(exec_pkg::xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            exec_pkg::alu_sltu:
                alu_out = {{(exec_pkg::xlen-1){1'b0}}, op_a < op_b};
            exec_pkg::alu_xor:    alu_out = op_a ^ op_b;
            exec_pkg::alu_srl:    alu_out = op_a >> shamt;
            exec_pkg::alu_sra:    alu_out = $signed(op_a) >>> shamt;
            exec_pkg::alu_or:     alu_out = op_a | op_b;
            exec_pkg::alu_and:    alu_out = op_a & op_b;
            exec_pkg::alu_pass_b: alu_out = op_b;
            default:              alu_out = '0;
        endcase
    end

    // Into DM1 next edge
    assign ex_result.valid = ex_op.valid;
    assign ex_result.rd    = ex_op.rd;
    assign ex_result.data  = alu_out;

endmodule

// File: logic/forwarding_unit.sv
module forwarding_unit (
    input  exec_pkg::ex_op_t ex_op,
    input  exec_pkg::stage_t dm1,
    input  exec_pkg::stage_t dm2,
    input  exec_pkg::stage_t dm3,
    input  exec_pkg::stage_t wb,
    output logic [2:0]       sel_a,
    output logic [2:0]       sel_b
);

    // Youngest matching stage wins
    function automatic logic [2:0] pick_src(
        input logic                            use_const,
        input logic [exec_pkg::reg_addr_w-1:0] rs,
        input exec_pkg::stage_t                s_dm1,
        input exec_pkg::stage_t                s_dm2,
        input exec_pkg::stage_t                s_dm3,
        input exec_pkg::stage_t                s_wb
    );
        logic [2:0] sel;
        if (use_const)
            sel = exec_pkg::src_const;
        else if (rs == '0)
            sel = exec_pkg::src_regfile;
        else if (s_dm1.rd == rs)
            sel = exec_pkg::src_dm1;
        else if (s_dm2.rd == rs)
            sel = exec_pkg::src_dm2;
        else if (s_dm3.rd == rs)
            sel = exec_pkg::src_dm3;
        else if (s_wb.rd == rs)
            sel = exec_pkg::src_wb;
        else
            sel = exec_pkg::src_regfile;
        return sel;
    endfunction

    // Bubbles and non-writing ops carry rd zero, so no valid check
    assign sel_a = pick_src(ex_op.const_a, ex_op.rs1, dm1, dm2, dm3, wb);
    assign sel_b = pick_src(ex_op.const_b, ex_op.rs2, dm1, dm2, dm3, wb);

    sel_in_range: assert final ((sel_a <= exec_pkg::src_wb) && (sel_b <= exec_pkg::src_wb));

endmodule

// File: logic/instr_decoder.sv
module instr_decoder (
    input  logic              clk,
    input  logic              rst_n,
    input  exec_pkg::wb_req_t wb_req,
    output logic              wb_ack,
    output exec_pkg::ex_op_t  ex_op
);

    exec_pkg::instr_u instr;
    exec_pkg::ex_op_t dec_op;

    // funct3 to ALU op, alt picks sub/sra where allowed
    function automatic exec_pkg::alu_op_e alu_from_f3(
        input logic [2:0] funct3,
        input logic       alt,
        input logic       reg_form
    );
        exec_pkg::alu_op_e op;
        case (funct3)
            exec_pkg::f3_add:  op = (alt && reg_form) ? exec_pkg::alu_sub : exec_pkg::alu_add;
            exec_pkg::f3_sll:  op = exec_pkg::alu_sll;
            exec_pkg::f3_slt:  op = exec_pkg::alu_slt;
            exec_pkg::f3_sltu: op = exec_pkg::alu_sltu;
            exec_pkg::f3_xor:  op = exec_pkg::alu_xor;
            exec_pkg::f3_srl:  op = alt ? exec_pkg::alu_sra : exec_pkg::alu_srl;
            exec_pkg::f3_or:   op = exec_pkg::alu_or;
            default:           op = exec_pkg::alu_and;
        endcase
        return op;
    endfunction

    // Accept every strobe in the cycle it shows up
    assign wb_ack = wb_req.cyc & wb_req.stb;
    assign instr  = wb_req.dat;

    always_comb
    begin
        // Undecoded default: no write, constant zero result
        dec_op         = '0;
        dec_op.valid   = 1'b1;
        dec_op.alu_op  = exec_pkg::alu_pass_b;
        dec_op.const_a = 1'b1;
        dec_op.const_b = 1'b1;
        case (instr.r_fields.opcode)
            exec_pkg::opc_op:
            begin
                dec_op.rs1     = instr.r_fields.rs1;
                dec_op.rs2     = instr.r_fields.rs2;
                dec_op.rd      = instr.r_fields.rd;
                dec_op.const_a = 1'b0;
                dec_op.const_b = 1'b0;
                dec_op.alu_op  = alu_from_f3(instr.r_fields.funct3,
                                             instr.r_fields.funct7[5], 1'b1);
            end
            exec_pkg::opc_op_imm:
            begin
                dec_op.rs1       = instr.i_fields.rs1;
                dec_op.rd        = instr.i_fields.rd;
                dec_op.const_a   = 1'b0;
                dec_op.const_val = {{20{instr.i_fields.imm12[11]}}, instr.i_fields.imm12};
                // srai carries its flag in the funct7 position
                dec_op.alu_op    = alu_from_f3(instr.i_fields.funct3,
                                               instr.r_fields.funct7[5], 1'b0);
            end
            exec_pkg::opc_lui:
            begin
                dec_op.rd        = instr.i_fields.rd;
                dec_op.const_val = {instr.i_fields.imm12, instr.i_fields.rs1,
                                    instr.i_fields.funct3, 12'b0};
            end
            default:
            begin
                dec_op.rd = '0;
            end
        endcase
    end

    // EX register, bubble when nothing is accepted
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            ex_op <= '0;
        else if (wb_ack)
            ex_op <= dec_op;
        else
            ex_op <= '0;
    end

    ack_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_req.cyc && wb_req.stb));

endmodule

// File: logic/register_file.sv
module register_file (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [exec_pkg::reg_addr_w-1:0]   rs1,
    input  logic [exec_pkg::reg_addr_w-1:0]   rs2,
    output logic [exec_pkg::xlen-1:0]         rdata1,
    output logic [exec_pkg::xlen-1:0]         rdata2,
    input  exec_pkg::stage_t                  wr
);

    // x0 has no storage
    logic [exec_pkg::xlen-1:0] regs [1:(2**exec_pkg::reg_addr_w)-1];

    //////////////////////////////
    // Read ports
    //////////////////////////////
    // Old value is seen during a write; WB forwarding covers it
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    //////////////////////////////
    // Write port
    //////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            regs <= '{default: '0};
        end
        else if (wr.valid && (wr.rd != '0))
        begin
            regs[wr.rd] <= wr.data;
        end
    end

endmodule

// File: logic/result_pipe.sv
module result_pipe (
    input  logic             clk,
    input  logic             rst_n,
    input  exec_pkg::stage_t ex_result,
    output exec_pkg::stage_t dm1,
    output exec_pkg::stage_t dm2,
    output exec_pkg::stage_t dm3,
    output exec_pkg::stage_t wb,
    output exec_pkg::stage_t retire
);

    //////////////////////////////
    // DM1 to WB delay line
    //////////////////////////////
    // DM stages only delay the result here
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            dm1 <= '0;
            dm2 <= '0;
            dm3 <= '0;
            wb  <= '0;
        end
        else
        begin
            dm1 <= ex_result;
            dm2 <= dm1;
            dm3 <= dm2;
            wb  <= dm3;
        end
    end

    // WB doubles as the retire port
    assign retire = wb;

    wb_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        wb.valid |-> !$isunknown(wb.data));

endmodule

// File: verif/exec_core_tb.sv
module exec_core_tb;

    localparam int clk_period = 40;
    localparam int n_latency  = 16;
    localparam int n_directed = 60;
    localparam int n_random   = 400;
    localparam int n_total    = n_latency + n_directed + n_random;

    logic              clk;
    logic              rst_n;
    exec_pkg::wb_req_t wb_req;
    logic              wb_ack;
    exec_pkg::stage_t  retire;

    integer      seed;
    int          cycle_cnt = 0;
    int          errors;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    string       test_name;
    logic [31:0] model_regs [0:31];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    int          exp_edge_q [$];

    exec_core uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_ack (wb_ack),
        .retire (retire)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(clk_period / 2) clk = ~clk;
    end

    // Edge counter for the latency check
    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    initial
    begin
        repeat (n_total * 4 + 200) @(posedge clk);
        $display("Watchdog timeout: the retire stream stopped before all tests finished");
        $display("Regression failed");
        $finish;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic reg_form, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0: r = (alt && reg_form) ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5:
            begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Executes in issue order, x0 never written
    task automatic model_issue(input logic [31:0] w);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        rd = w[11:7];
        a  = model_regs[w[19:15]];
        case (w[6:0])
            exec_pkg::opc_op:
            begin
                b   = model_regs[w[24:20]];
                res = alu_ref(w[14:12], w[30], 1'b1, a, b);
            end
            exec_pkg::opc_op_imm:
            begin
                b   = {{20{w[31]}}, w[31:20]};
                res = alu_ref(w[14:12], w[30], 1'b0, a, b);
            end
            exec_pkg::opc_lui:
                res = {w[31:12], 12'b0};
            default:
            begin
                rd  = '0;
                res = '0;
            end
        endcase
        if (rd != 0)
            model_regs[rd] = res;
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(res);
        exp_edge_q.push_back(cycle_cnt + 1);
    endtask

    //////////////////////////////
    // Instruction words
    //////////////////////////////
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, exec_pkg::opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, exec_pkg::opc_op_imm};
    endfunction

    // Kind 0 is undecoded, registers stay in x0 to x7
    function automatic logic [31:0] rand_instr();
        logic [31:0] r;
        logic [31:0] r2;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [6:0]  f7;
        logic [6:0]  opc;
        r   = $random(seed);
        r2  = $random(seed);
        f3  = r[5:3];
        rd  = {2'b0, r[8:6]};
        rs1 = {2'b0, r[11:9]};
        rs2 = {2'b0, r[14:12]};
        case (r[2:0])
            3'd0:
            begin
                case (r[17:16])
                    2'd0: opc = 7'h03;
                    2'd1: opc = 7'h23;
                    2'd2: opc = 7'h63;
                    default: opc = 7'h6f;
                endcase
                return {r2[31:7], opc};
            end
            3'd1, 3'd2, 3'd3:
            begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[15]) ? 7'h20 : 7'h00;
                return enc_r(f7, rs2, rs1, f3, rd);
            end
            3'd7:
                return {r2[19:0], rd, exec_pkg::opc_lui};
            default:
            begin
                imm = r2[11:0];
                if (f3 == 3'd1)
                    imm = {7'h00, r2[4:0]};
                else if (f3 == 3'd5)
                    imm = {(r[15] ? 7'h20 : 7'h00), r2[4:0]};
                return enc_i(imm, rs1, f3, rd);
            end
        endcase
    endfunction

    //////////////////////////////
    // Driving and checking
    //////////////////////////////
    task automatic check_retire();
        logic [4:0]  e_rd;
        logic [31:0] e_data;
        int          e_edge;
        if (retire.valid)
        begin
            if (exp_rd_q.size() == 0)
            begin
                $display("%s: retire went valid with no instruction in flight", test_name);
                errors++;
            end
            else
            begin
                e_rd   = exp_rd_q.pop_front();
                e_data = exp_data_q.pop_front();
                e_edge = exp_edge_q.pop_front();
                if (retire.rd !== e_rd)
                begin
                    $display("Error %s: rd expected %0d actual %0d", test_name, e_rd, retire.rd);
                    errors++;
                end
                if (retire.data !== e_data)
                begin
                    $display("Error %s: data expected %h actual %h", test_name, e_data,
                             retire.data);
                    errors++;
                end
                if (cycle_cnt != e_edge + 4)
                begin
                    $display("Error %s: retire edge expected %0d actual %0d", test_name,
                             e_edge + 4, cycle_cnt);
                    errors++;
                end
            end
        end
    endtask

    // One falling edge: check retire, then drive the bus
    task automatic step(input logic cyc, input logic stb, input logic [31:0] w);
        @(negedge clk);
        check_retire();
        wb_req = {cyc, stb, w};
        #1;
        if (wb_ack !== (cyc & stb))
        begin
            $display("Error %s: ack expected %b actual %b", test_name, cyc & stb, wb_ack);
            errors++;
        end
        if (cyc && stb)
            model_issue(w);
    endtask

    task automatic issue(input logic [31:0] w);
        step(1'b1, 1'b1, w);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    // Drain the pipe, then a few idle cycles with no stray retire
    task automatic end_test();
        while (exp_rd_q.size() != 0)
            step(1'b0, 1'b0, 32'h0);
        repeat (3)
            step(1'b0, 1'b0, 32'h0);
        if (errors == test_errors)
        begin
            $display("Test %-12s ok", test_name);
            tests_passed++;
        end
        else
        begin
            $display("Test %-12s FAILED with %0d errors", test_name, errors - test_errors);
            tests_failed++;
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial
    begin
        int          gap;
        int          side;
        int          k;
        logic [31:0] w;
        logic [31:0] r;
        logic        stb;
        seed         = 11713;
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name    = "reset";
        for (k = 0; k < 32; k++)
            model_regs[k] = '0;
        rst_n  = 1'b0;
        wb_req = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Idle bus combinations must not ack or retire
        start_test("reset_idle");
        for (k = 0; k < 4; k++)
        begin
            step(1'b1, 1'b0, 32'h1234_5000 + k);
            step(1'b0, 1'b1, 32'h0abc_d000 + k);
            step(1'b0, 1'b0, 32'h0);
        end
        end_test();

        start_test("latency");
        repeat (n_latency)
            issue(rand_instr());
        end_test();

        start_test("forwarding");
        issue(enc_i(12'd7, 5'd0, exec_pkg::f3_add, 5'd1));
        for (gap = 0; gap < 4; gap++)
        begin
            for (side = 0; side < 2; side++)
            begin
                issue(enc_i(12'd37 + gap, 5'd5, exec_pkg::f3_add, 5'd5));
                repeat (gap)
                    issue(enc_i(gap, 5'd7, exec_pkg::f3_add, 5'd6));
                if (side == 0)
                    issue(enc_r(7'h00, 5'd1, 5'd5, exec_pkg::f3_add, 5'd3));
                else
                    issue(enc_r(7'h20, 5'd5, 5'd1, exec_pkg::f3_add, 5'd4));
            end
        end
        // x5 held in DM1, DM2 and DM3 at once
        issue(enc_i(12'd11, 5'd0, exec_pkg::f3_add, 5'd5));
        issue(enc_i(12'd22, 5'd0, exec_pkg::f3_add, 5'd5));
        issue(enc_i(12'd33, 5'd0, exec_pkg::f3_add, 5'd5));
        issue(enc_r(7'h00, 5'd0, 5'd5, exec_pkg::f3_add, 5'd3));
        // x5 in DM2 and WB
        issue(enc_i(12'd44, 5'd0, exec_pkg::f3_add, 5'd5));
        issue(enc_i(12'd1, 5'd0, exec_pkg::f3_add, 5'd6));
        issue(enc_i(12'd55, 5'd0, exec_pkg::f3_add, 5'd5));
        issue(enc_i(12'd2, 5'd0, exec_pkg::f3_add, 5'd7));
        issue(enc_r(7'h00, 5'd5, 5'd0, exec_pkg::f3_add, 5'd3));
        end_test();

        // Random ops with random bubbles
        start_test("random_alu");
        for (k = 0; k < n_random; k++)
        begin
            w = rand_instr();
            do
            begin
                r   = $random(seed);
                stb = (r[1:0] != 2'd0);
                step(1'b1, stb, w);
            end
            while (!stb);
        end
        end_test();

        start_test("x0_undecoded");
        issue(enc_i(12'h123, 5'd1, exec_pkg::f3_add, 5'd0));
        issue(enc_r(7'h00, 5'd0, 5'd0, exec_pkg::f3_or, 5'd2));
        issue({20'hfffff, 5'd0, exec_pkg::opc_lui});
        issue(enc_i(12'h0, 5'd0, exec_pkg::f3_xor, 5'd3));
        issue(32'h00a2_82a3);
        issue(32'h0052_8263);
        issue(32'hfff0_036f);
        for (k = 1; k < 8; k++)
            issue(enc_i(12'h0, k, exec_pkg::f3_add, k));
        end_test();

        $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: vlog.f
logic/exec_pkg.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/forwarding_unit.sv
logic/execute_stage.sv
logic/result_pipe.sv
logic/exec_core.sv
verif/exec_core_tb.sv
